//--- list.f
hdl/watch_pkg.sv
hdl/cal_if.sv
hdl/sec_prescaler.sv
hdl/watch_date.sv
hdl/alarm_match.sv
hdl/watch_regs.sv
hdl/watch_top.sv
bench/watch_tb.sv

//--- run.sh
#!/bin/sh
set -e
cd "$(dirname "$0")"

verilator --binary -j 0 --top-module watch_tb -f list.f
out=$(./obj_dir/Vwatch_tb)
echo "$out"

if echo "$out" | grep -qx "ALL CHECKS PASSED"; then
	exit 0
fi
exit 1

//--- bench/watch_tb.sv
`default_nettype none

module watch_tb import watch_pkg::*; ();

	localparam int unsigned planned_seconds = 112;            // 20 random runs of up to 5 s, then directed runs
	localparam int unsigned watchdog_time = planned_seconds * ticks_per_sec * 10 + 40000;

	logic clk = 1'b0;
	logic rst;
	logic psel;
	logic penable;
	logic pwrite;
	logic [4:0] paddr;
	logic [31:0] pwdata;
	logic [31:0] prdata;
	logic pready;
	logic pslverr;
	logic irq;

	logic [31:0] lfsr_state = 32'hef29;
	int checks = 0;
	int time_errs = 0;
	int word_errs = 0;
	int flag_errs = 0;

	time_fields_t exp_time_q[$];
	time_fields_t got_time_q[$];
	logic [31:0] exp_word_q[$];
	logic [31:0] got_word_q[$];
	logic exp_flag_q[$];
	logic got_flag_q[$];
	string flag_name_q[$];

	watch_top u_dut (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.irq(irq)
	);

	always #5 clk = ~clk;

	////////////////////
	// Reference calendar

	function automatic logic [7:0] month_len(input logic [7:0] m);
		case (m)
			8'd2: return 8'd28;                                  // No leap years
			8'd4, 8'd6, 8'd9, 8'd11: return 8'd30;
			default: return 8'd31;
		endcase
	endfunction

	function automatic time_fields_t next_second(input time_fields_t t);
		time_fields_t n;
		n = t;
		if (n.second != 8'd59) begin
			n.second = n.second + 8'd1;
			return n;
		end
		n.second = 8'd0;
		if (n.minute != 8'd59) begin
			n.minute = n.minute + 8'd1;
			return n;
		end
		n.minute = 8'd0;
		if (n.hour != 8'd23) begin
			n.hour = n.hour + 8'd1;
			return n;
		end
		n.hour = 8'd0;
		if (n.day != month_len(n.month)) begin
			n.day = n.day + 8'd1;
			return n;
		end
		n.day = 8'd1;
		if (n.month != 8'd12) begin
			n.month = n.month + 8'd1;
			return n;
		end
		n.month = 8'd1;
		n.year = (n.year == max_year) ? 8'd1 : n.year + 8'd1;   // Year 0 is skipped
		return n;
	endfunction

	function automatic time_fields_t make_time(input int y, input int mo, input int d,
		input int h, input int mi, input int s);
		time_fields_t t;
		t.year = 8'(y);
		t.month = 8'(mo);
		t.day = 8'(d);
		t.hour = 8'(h);
		t.minute = 8'(mi);
		t.second = 8'(s);
		return t;
	endfunction

	function automatic string time_str(input time_fields_t t);
		return $sformatf("%0d-%0d-%0d %02d:%02d:%02d", t.year, t.month, t.day,
			t.hour, t.minute, t.second);
	endfunction

	////////////////////
	// Random stimulus

	function automatic logic [31:0] lfsr_next(input logic [31:0] s);
		return s[0] ? ((s >> 1) ^ 32'h8020_0003) : (s >> 1);
	endfunction

	// One LFSR step per bit taken
	function automatic int unsigned rand_bits(input int n);
		int unsigned v;
		v = 0;
		for (int i = 0; i < n; i++) begin
			v = (v << 1) | (lfsr_state[0] ? 1 : 0);
			lfsr_state = lfsr_next(lfsr_state);
		end
		return v;
	endfunction

	function automatic time_fields_t random_time();
		time_fields_t t;
		t.year = 8'(rand_bits(8));
		if (t.year == 8'd0) begin
			t.year = 8'd1;
		end
		t.month = 8'(rand_bits(4) % 12 + 1);
		t.day = 8'(rand_bits(5) % int'(month_len(t.month)) + 1);
		t.hour = 8'(rand_bits(5) % 24);
		t.minute = 8'(rand_bits(6) % 60);
		t.second = 8'(rand_bits(6) % 60);
		return t;
	endfunction

	////////////////////
	// Checks

	task automatic expect_time(input time_fields_t exp, input time_fields_t got);
		exp_time_q.push_back(exp);
		got_time_q.push_back(got);
	endtask

	task automatic expect_word(input logic [31:0] exp, input logic [31:0] got);
		exp_word_q.push_back(exp);
		got_word_q.push_back(got);
	endtask

	task automatic expect_flag(input string name, input logic exp, input logic got);
		flag_name_q.push_back(name);
		exp_flag_q.push_back(exp);
		got_flag_q.push_back(got);
	endtask

	task automatic check_time(input time_fields_t exp, input time_fields_t got);
		checks++;
		if (got !== exp) begin
			time_errs++;
			$display("** Error at %0t: time %s, expected %s", $time, time_str(got), time_str(exp));
		end
	endtask

	task automatic check_word(input logic [31:0] exp, input logic [31:0] got);
		checks++;
		if (got !== exp) begin
			word_errs++;
			$display("** Error at %0t: register word %h, expected %h", $time, got, exp);
		end
	endtask

	task automatic check_flag(input string name, input logic exp, input logic got);
		checks++;
		if (got !== exp) begin
			flag_errs++;
			$display("** Error at %0t: %s is %b, expected %b", $time, name, got, exp);
		end
	endtask

	always @(negedge clk) begin
		string name;
		logic fe;
		while (exp_time_q.size() > 0) begin
			check_time(exp_time_q.pop_front(), got_time_q.pop_front());
		end
		while (exp_word_q.size() > 0) begin
			check_word(exp_word_q.pop_front(), got_word_q.pop_front());
		end
		while (exp_flag_q.size() > 0) begin
			name = flag_name_q.pop_front();
			fe = exp_flag_q.pop_front();
			check_flag(name, fe, got_flag_q.pop_front());
		end
	end

	////////////////////
	// Bus tasks

	task automatic apb_write(input logic [4:0] addr, input logic [31:0] data);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b1;
		paddr <= addr;
		pwdata <= data;
		@(posedge clk);
		penable <= 1'b1;
		@(posedge clk);                                          // Write lands at this edge
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic apb_read(input logic [4:0] addr, output logic [31:0] data,
		output logic err, output logic rdy);
		@(posedge clk);
		psel <= 1'b1;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= addr;
		@(posedge clk);
		penable <= 1'b1;
		@(negedge clk);                                          // Mid access cycle
		data = prdata;
		err = pslverr;
		rdy = pready;
		@(posedge clk);
		psel <= 1'b0;
		penable <= 1'b0;
	endtask

	task automatic read_time(output time_fields_t t);
		logic [31:0] lo;
		logic [31:0] hi;
		logic err;
		logic rdy;
		apb_read(addr_time_lo, lo, err, rdy);
		expect_flag("pslverr", 1'b0, err);
		apb_read(addr_time_hi, hi, err, rdy);
		expect_flag("pslverr", 1'b0, err);
		t.year = hi[23:16];
		t.month = hi[15:8];
		t.day = hi[7:0];
		t.hour = lo[23:16];
		t.minute = lo[15:8];
		t.second = lo[7:0];
	endtask

	task automatic load_time(input time_fields_t t, input logic alarm_en);
		logic [31:0] ctrl;
		ctrl = 32'd0;
		ctrl[ctrl_load_bit] = 1'b1;
		ctrl[ctrl_alarm_en_bit] = alarm_en;
		apb_write(addr_time_lo, {8'h00, t.hour, t.minute, t.second});
		apb_write(addr_time_hi, {8'h00, t.year, t.month, t.day});
		apb_write(addr_ctrl, ctrl);
	endtask

	// Counted from the end of the load write, the k-th advance has just happened
	task automatic run_seconds(input int k);
		repeat (1 + ticks_per_sec * k) @(posedge clk);
	endtask

	task automatic load_and_check(input time_fields_t t, input int k, output time_fields_t got);
		time_fields_t exp;
		load_time(t, 1'b0);
		run_seconds(k);
		read_time(got);
		exp = t;
		repeat (k) begin
			exp = next_second(exp);
		end
		expect_time(exp, got);
	endtask

	task automatic expect_irq(input logic exp);
		@(negedge clk);
		expect_flag("irq", exp, irq);
	endtask

	////////////////////
	// Test sequence

	initial begin
		time_fields_t t;
		time_fields_t got;
		logic [31:0] lo;
		logic [31:0] hi;
		logic err;
		logic rdy;
		int k;
		rst <= 1'b0;
		psel <= 1'b0;
		penable <= 1'b0;
		pwrite <= 1'b0;
		paddr <= 5'd0;
		pwdata <= 32'd0;
		repeat (4) @(posedge clk);
		rst <= 1'b1;

		read_time(got);
		expect_time(make_time(21, 5, 30, 0, 0, 0), got);
		expect_irq(1'b0);

		for (int i = 0; i < 20; i++) begin
			t = random_time();
			k = int'(rand_bits(3) % 6);
			load_and_check(t, k, got);
		end

		load_and_check(make_time(50, 4, 30, 23, 59, 59), 1, got);
		load_and_check(make_time(50, 7, 31, 23, 59, 59), 1, got);
		load_and_check(make_time(50, 2, 28, 23, 59, 59), 1, got);
		load_and_check(make_time(99, 12, 31, 23, 59, 59), 1, got);
		load_and_check(make_time(255, 12, 31, 23, 59, 59), 1, got);
		expect_time(make_time(1, 1, 1, 0, 0, 0), got);

		// Low half read right before the tick, high half right after it
		t = make_time(40, 4, 30, 23, 59, 59);
		load_time(t, 1'b0);
		repeat (ticks_per_sec - 3) @(posedge clk);
		apb_read(addr_time_lo, lo, err, rdy);
		apb_read(addr_time_hi, hi, err, rdy);
		expect_word({8'h00, 8'd23, 8'd59, 8'd59}, lo);
		expect_word({8'h00, 8'd40, 8'd4, 8'd30}, hi);
		read_time(got);
		expect_time(next_second(t), got);

		t = make_time(30, 6, 15, 6, 59, 57);
		apb_write(addr_alarm, {16'h0000, 8'd7, 8'd0});
		apb_read(addr_alarm, lo, err, rdy);
		expect_word(32'h0000_0700, lo);
		apb_write(addr_ctrl, 32'h0000_0002);
		apb_read(addr_ctrl, lo, err, rdy);
		expect_word(32'h0000_0002, lo);
		load_time(t, 1'b1);
		run_seconds(2);
		expect_irq(1'b0);
		repeat (ticks_per_sec) @(posedge clk);                   // Third tick enters 07:00:00
		expect_irq(1'b1);
		apb_read(addr_status, lo, err, rdy);
		expect_word(32'd1, lo);
		apb_write(addr_status, 32'd1);
		expect_irq(1'b0);
		load_time(t, 1'b0);
		run_seconds(3);
		expect_irq(1'b0);

		t = make_time(77, 9, 12, 10, 20, 30);
		load_time(t, 1'b0);
		run_seconds(0);
		apb_read(5'h14, lo, err, rdy);
		expect_flag("pslverr", 1'b1, err);
		expect_flag("pready", 1'b1, rdy);
		read_time(got);
		expect_time(t, got);
		apb_read(5'h1C, lo, err, rdy);
		expect_flag("pslverr", 1'b1, err);

		repeat (2) @(negedge clk);
		$display("Checks run: %0d, errors: %0d (time %0d, word %0d, flag %0d)", checks,
			time_errs + word_errs + flag_errs, time_errs, word_errs, flag_errs);
		if (time_errs + word_errs + flag_errs == 0) begin
			$display("ALL CHECKS PASSED");
		end else begin
			$display("CHECKS FAILED");
		end
		$finish;
	end

	initial begin
		#(watchdog_time);
		$display("Watchdog expired before the test sequence finished");
		$display("CHECKS FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- hdl/watch_top.sv
`default_nettype none

module watch_top (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [4:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	output logic irq
);

	logic [7:0] alarm_hour;
	logic [7:0] alarm_minute;
	logic alarm_en;
	logic pending;
	logic clear;

	cal_if u_cal ();

	watch_regs u_regs (
		.clk(clk),
		.rst(rst),
		.psel(psel),
		.penable(penable),
		.pwrite(pwrite),
		.paddr(paddr),
		.pwdata(pwdata),
		.prdata(prdata),
		.pready(pready),
		.pslverr(pslverr),
		.cal(u_cal.ctrl),
		.alarm_hour(alarm_hour),
		.alarm_minute(alarm_minute),
		.alarm_en(alarm_en),
		.pending(pending),
		.clear(clear)
	);

	sec_prescaler u_presc (
		.clk(clk),
		.rst(rst),
		.cal(u_cal.prescale)
	);

	watch_date u_date (
		.clk(clk),
		.rst(rst),
		.cal(u_cal.counter)
	);

	alarm_match u_alarm (
		.clk(clk),
		.rst(rst),
		.cal(u_cal.monitor),
		.alarm_hour(alarm_hour),
		.alarm_minute(alarm_minute),
		.alarm_en(alarm_en),
		.clear(clear),
		.pending(pending)
	);

	assign irq = pending;                                 // Level interrupt while the alarm is pending

endmodule

`default_nettype wire

//--- hdl/watch_regs.sv
`default_nettype none

module watch_regs import watch_pkg::*; (
	input logic clk,
	input logic rst,
	input logic psel,
	input logic penable,
	input logic pwrite,
	input logic [4:0] paddr,
	input logic [31:0] pwdata,
	output logic [31:0] prdata,
	output logic pready,
	output logic pslverr,
	cal_if.ctrl cal,
	output logic [7:0] alarm_hour,
	output logic [7:0] alarm_minute,
	output logic alarm_en,
	input logic pending,
	output logic clear
);

	time_word_u stage;
	logic [23:0] snap_hi;
	logic access;
	logic wr;
	logic rd;
	logic addr_ok;
	logic load_wr;

	assign access = psel && penable;
	assign wr = access && pwrite;
	assign rd = access && !pwrite;
	assign pready = 1'b1;                                 // No wait states

	////////////////////
	// Address decode

	always_comb begin
		case (paddr)
			addr_time_lo, addr_time_hi, addr_ctrl, addr_alarm, addr_status: addr_ok = 1'b1;
			default: addr_ok = 1'b0;
		endcase
	end

	assign pslverr = access && !addr_ok;

	always_comb begin
		case (paddr)
			addr_time_lo: prdata = {8'h00, cal.now.raw[23:0]};
			addr_time_hi: prdata = {8'h00, snap_hi};       // Date latched by the last time_lo read
			addr_ctrl: prdata = {30'd0, alarm_en, 1'b0};  // Load bit reads as zero
			addr_alarm: prdata = {16'h0000, alarm_hour, alarm_minute};
			addr_status: prdata = {31'd0, pending};
			default: prdata = 32'd0;
		endcase
	end

	////////////////////
	// Writes

	assign load_wr = wr && (paddr == addr_ctrl) && pwdata[ctrl_load_bit];
	assign clear = wr && (paddr == addr_status) && pwdata[0];

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			stage.raw <= 48'd0;
			snap_hi <= 24'd0;
			alarm_hour <= 8'd0;
			alarm_minute <= 8'd0;
			alarm_en <= 1'b0;
			cal.load <= 1'b0;
		end else begin
			cal.load <= load_wr;                        // Single cycle pulse
			if (rd && (paddr == addr_time_lo)) begin
				snap_hi <= cal.now.raw[47:24];
			end
			if (wr) begin
				case (paddr)
					addr_time_lo: stage.raw[23:0] <= pwdata[23:0];
					addr_time_hi: stage.raw[47:24] <= pwdata[23:0];
					addr_ctrl: alarm_en <= pwdata[ctrl_alarm_en_bit];
					addr_alarm: begin
						alarm_minute <= pwdata[7:0];
						alarm_hour <= pwdata[15:8];
					end
					default: ;
				endcase
			end
		end
	end

	// Staged time travels with the load pulse
	always_ff @(posedge clk) begin
		if (load_wr) begin
			cal.load_time.raw <= stage.raw;
		end
	end

endmodule

`default_nettype wire

//--- hdl/alarm_match.sv
`default_nettype none

module alarm_match (
	input logic clk,
	input logic rst,
	cal_if.monitor cal,
	input logic [7:0] alarm_hour,
	input logic [7:0] alarm_minute,
	input logic alarm_en,
	input logic clear,
	output logic pending
);

	logic [7:0] prev_hour;
	logic [7:0] prev_minute;
	logic one_before;
	logic hit;

	////////////////////
	// One second before the alarm

	// The time at hh:mm:00 minus one second, borrowing into the hour
	always_comb begin
		if (alarm_minute == 8'd0) begin
			prev_minute = 8'd59;
			if (alarm_hour == 8'd0) begin
				prev_hour = 8'd23;                     // Alarm at midnight, so the day before
			end else begin
				prev_hour = alarm_hour - 8'd1;
			end
		end else begin
			prev_minute = alarm_minute - 8'd1;
			prev_hour = alarm_hour;
		end
	end

	assign one_before = (cal.now.f.second == 8'd59) &&
		(cal.now.f.minute == prev_minute) &&
		(cal.now.f.hour == prev_hour);

	assign hit = cal.tick && alarm_en && one_before;

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			pending <= 1'b0;
		end else if (hit) begin
			pending <= 1'b1;                           // A new hit wins over a clear
		end else if (clear) begin
			pending <= 1'b0;
		end
	end

endmodule

`default_nettype wire

//--- hdl/watch_date.sv
`default_nettype none

module watch_date import watch_pkg::*; (
	input logic clk,
	input logic rst,
	cal_if.counter cal
);

	time_word_u cur;
	logic [7:0] max_day;
	logic sec_end;
	logic min_end;
	logic hour_end;
	logic day_end;
	logic year_end;
	logic cal_wrap;

	assign cal.now = cur;

	////////////////////
	// Month length

	// February is fixed at 28 days
	always_comb begin
		case (cur.f.month)
			8'd1, 8'd3, 8'd5, 8'd7, 8'd8, 8'd10, 8'd12: max_day = 8'd31;
			8'd2: max_day = 8'd28;
			8'd4, 8'd6, 8'd9, 8'd11: max_day = 8'd30;
			default: max_day = 8'd0;
		endcase
	end

	////////////////////
	// Rollover chain

	assign sec_end = (cur.f.second == 8'd59);
	assign min_end = sec_end && (cur.f.minute == 8'd59);
	assign hour_end = min_end && (cur.f.hour == 8'd23);
	assign day_end = hour_end && (cur.f.day == max_day);
	assign year_end = day_end && (cur.f.month == 8'd12);
	assign cal_wrap = year_end && (cur.f.year == max_year);

	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			cur.f.year <= reset_year;
			cur.f.month <= reset_month;
			cur.f.day <= reset_day;
			cur.f.hour <= 8'd0;
			cur.f.minute <= 8'd0;
			cur.f.second <= 8'd0;
		end else if (cal.load) begin
			cur.f <= cal.load_time.f;                // Load beats a tick in the same cycle
		end else if (cal.tick) begin
			if (cal_wrap) begin
				cur.f.year <= 8'd1;
				cur.f.month <= 8'd1;
				cur.f.day <= 8'd1;
				cur.f.hour <= 8'd0;
				cur.f.minute <= 8'd0;
				cur.f.second <= 8'd0;
			end else if (year_end) begin
				cur.f.year <= cur.f.year + 8'd1;
				cur.f.month <= 8'd1;
				cur.f.day <= 8'd1;
				cur.f.hour <= 8'd0;
				cur.f.minute <= 8'd0;
				cur.f.second <= 8'd0;
			end else if (day_end) begin
				cur.f.month <= cur.f.month + 8'd1;
				cur.f.day <= 8'd1;
				cur.f.hour <= 8'd0;
				cur.f.minute <= 8'd0;
				cur.f.second <= 8'd0;
			end else if (hour_end) begin
				cur.f.day <= cur.f.day + 8'd1;
				cur.f.hour <= 8'd0;
				cur.f.minute <= 8'd0;
				cur.f.second <= 8'd0;
			end else if (min_end) begin
				cur.f.hour <= cur.f.hour + 8'd1;
				cur.f.minute <= 8'd0;
				cur.f.second <= 8'd0;
			end else if (sec_end) begin
				cur.f.minute <= cur.f.minute + 8'd1;
				cur.f.second <= 8'd0;
			end else begin
				cur.f.second <= cur.f.second + 8'd1;
			end
		end
	end

endmodule

`default_nettype wire

//--- hdl/sec_prescaler.sv
`default_nettype none

module sec_prescaler import watch_pkg::*; (
	input logic clk,
	input logic rst,
	cal_if.prescale cal
);

	localparam logic [presc_w-1:0] last_count = presc_w'(ticks_per_sec - 1);

	logic [presc_w-1:0] count;

	// A load restarts the second so the new time gets a full first second
	always_ff @(posedge clk or negedge rst) begin
		if (!rst) begin
			count <= '0;
		end else if (cal.load) begin
			count <= '0;
		end else if (count == last_count) begin
			count <= '0;
		end else begin
			count <= count + 1'b1;
		end
	end

	assign cal.tick = (count == last_count);          // High for the terminal count only

endmodule

`default_nettype wire

//--- hdl/cal_if.sv
`default_nettype none

interface cal_if import watch_pkg::*; ();

	logic load;                 // One cycle request to take load_time
	time_word_u load_time;
	time_word_u now;            // Running calendar time
	logic tick;                 // One cycle per second

	modport ctrl (
		output load,
		output load_time,
		input now
	);

	modport counter (
		input load,
		input load_time,
		input tick,
		output now
	);

	modport prescale (
		input load,
		output tick
	);

	modport monitor (
		input now,
		input tick
	);

endinterface

`default_nettype wire

//--- hdl/watch_pkg.sv
`default_nettype none

package watch_pkg;

	////////////////////
	// Timing

	localparam int unsigned ticks_per_sec = 8;                 // Kept small for simulation
	localparam int unsigned presc_w = $clog2(ticks_per_sec);

	////////////////////
	// Calendar

	localparam logic [7:0] reset_year = 8'd21;
	localparam logic [7:0] reset_month = 8'd5;
	localparam logic [7:0] reset_day = 8'd30;
	localparam logic [7:0] max_year = 8'd255;                  // Next year after this is 1

	typedef struct packed {
		logic [7:0] year;
		logic [7:0] month;
		logic [7:0] day;
		logic [7:0] hour;
		logic [7:0] minute;
		logic [7:0] second;
	} time_fields_t;

	typedef union packed {
		time_fields_t f;
		logic [47:0] raw;
	} time_word_u;

	////////////////////
	// Register map

	localparam logic [4:0] addr_time_lo = 5'h00;               // Hour, minute, second
	localparam logic [4:0] addr_time_hi = 5'h04;               // Year, month, day
	localparam logic [4:0] addr_ctrl = 5'h08;
	localparam logic [4:0] addr_alarm = 5'h0C;                 // Hour, minute
	localparam logic [4:0] addr_status = 5'h10;

	localparam int unsigned ctrl_load_bit = 0;
	localparam int unsigned ctrl_alarm_en_bit = 1;

endpackage

`default_nettype wire
